// File: trg_pkg.sv
package trg_pkg;

  // stream geometry
  localparam int tdata_w = 128;
  localparam int lane_w  = 16;
  localparam int adc_w   = 12;
  localparam int lanes   = tdata_w / lane_w;

  localparam int time_w  = 44;
  localparam int len_w   = 16;

  // register bus widths
  localparam int axil_aw = 5;
  localparam int axil_dw = 32;

  typedef logic [tdata_w-1:0]      beat_t;
  typedef logic signed [adc_w-1:0] sample_t;
  typedef logic [time_w-1:0]       time_t;
  typedef logic [len_w-1:0]        len_t;

  // byte offsets in the register map
  localparam logic [axil_aw-1:0] reg_ctrl    = 5'h00;
  localparam logic [axil_aw-1:0] reg_thresh  = 5'h04;
  localparam logic [axil_aw-1:0] reg_base    = 5'h08;
  localparam logic [axil_aw-1:0] reg_post    = 5'h0C;
  localparam logic [axil_aw-1:0] reg_acqui   = 5'h10;
  localparam logic [axil_aw-1:0] reg_evcnt   = 5'h14;
  localparam logic [axil_aw-1:0] reg_time_lo = 5'h18;
  localparam logic [axil_aw-1:0] reg_time_hi = 5'h1C;

  // bits of reg_ctrl
  localparam int ctrl_enable_bit = 0;
  localparam int ctrl_clear_bit  = 1;

  localparam sample_t thresh_rst = sample_t'(100);
  localparam sample_t base_rst   = sample_t'(0);
  localparam len_t    post_rst   = len_t'(38);
  localparam len_t    acqui_rst  = len_t'(100);
  localparam logic    enable_rst = 1'b1;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // compare register plus trigger mark register
  localparam int hit_lat = 2;

endpackage

// File: trg_align_pipe.sv
module trg_align_pipe #(
  parameter type payload_t = logic,
  parameter int  depth     = 1
) (
  input  logic     AXIS_ACLK,
  input  logic     hit_flag_negedge,
  input  payload_t in_data,
  input  logic     in_valid,
  output payload_t out_data,
  output logic     out_valid
);

  payload_t         data_q [depth];
  logic [depth-1:0] valid_q;

  // valid bit per stage
  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= in_valid;
      for (int i = 1; i < depth; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // a stage only loads when the word entering it is valid
  always_ff @(posedge AXIS_ACLK) begin
    if (in_valid) begin
      data_q[0] <= in_data;
    end
    for (int i = 1; i < depth; i++) begin
      if (valid_q[i-1]) begin
        data_q[i] <= data_q[i-1];
      end
    end
  end

  assign out_data  = data_q[depth-1];
  assign out_valid = valid_q[depth-1];

endmodule

// File: trg_sample_compare.sv
module trg_sample_compare (
  input  logic             AXIS_ACLK,
  input  logic             hit_flag_negedge,
  input  trg_pkg::beat_t   s_axis_tdata,
  input  logic             s_axis_tvalid,
  input  logic             enable,
  input  trg_pkg::sample_t thresh,
  input  trg_pkg::sample_t base,
  output logic             hit
);
  import trg_pkg::*;

  // one extra bit so sample minus baseline never wraps
  typedef logic signed [adc_w:0] wide_t;

  sample_t          sample [lanes];
  wide_t            diff   [lanes];
  wide_t            thresh_w;
  wide_t            base_w;
  logic [lanes-1:0] above;

  assign thresh_w = {thresh[adc_w-1], thresh};
  assign base_w   = {base[adc_w-1], base};

  for (genvar i = 0; i < lanes; i++) begin : g_lane
    // sample sits in the upper bits of its lane
    assign sample[i] = s_axis_tdata[lane_w*i + lane_w - 1 -: adc_w];
    assign diff[i]   = {sample[i][adc_w-1], sample[i]} - base_w;
    assign above[i]  = (diff[i] >= thresh_w);
  end

  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      hit <= 1'b0;
    end else begin
      hit <= s_axis_tvalid && enable && (|above);
    end
  end

endmodule

// File: trg_window_ctrl.sv
module trg_window_ctrl (
  input  logic             AXIS_ACLK,
  input  logic             hit_flag_negedge,
  input  logic             hit,
  input  logic             beat_valid,
  input  trg_pkg::len_t    post_len,
  input  trg_pkg::len_t    acqui_len,
  input  trg_pkg::sample_t thresh,
  input  trg_pkg::sample_t base,
  input  trg_pkg::time_t   hit_time,
  output logic             triggered,
  output logic             event_start,
  output trg_pkg::time_t   time_stamp,
  output trg_pkg::sample_t baseline_when_hit,
  output trg_pkg::sample_t threshold_when_hit
);
  import trg_pkg::*;

  logic hit_q;
  logic hit_rise;
  logic hit_fall;

  // cycles spent in the post window, counted from the falling edge
  len_t post_cnt;
  // cycles since the rising edge
  len_t acqui_cnt;

  // previous cycle was inside the post window
  logic finalize_flag;
  // acquisition ran past acqui_len
  logic over_len_flag;

  logic post_active;
  logic over_len;
  logic mark;

  assign hit_rise    = hit && !hit_q;
  assign hit_fall    = !hit && hit_q;
  assign event_start = hit_rise;

  // the falling-edge cycle is the first of post_len cycles
  assign post_active = !hit && (hit_fall ? (post_len != '0)
                                         : (finalize_flag && (post_cnt < post_len)));

  // the rising-edge cycle is the first of acqui_len cycles
  assign over_len = hit_rise ? (acqui_len == '0)
                             : (over_len_flag || (acqui_cnt >= acqui_len));

  assign mark = beat_valid && !over_len && (hit || post_active);

  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      hit_q         <= 1'b0;
      post_cnt      <= '0;
      acqui_cnt     <= '0;
      finalize_flag <= 1'b0;
      over_len_flag <= 1'b0;
      triggered     <= 1'b0;
    end else begin
      hit_q         <= hit;
      finalize_flag <= post_active;
      over_len_flag <= over_len;
      triggered     <= mark;

      // saturating counters
      if (hit_fall) begin
        post_cnt <= len_t'(1);
      end else if (post_cnt != '1) begin
        post_cnt <= post_cnt + 1'b1;
      end

      if (hit_rise) begin
        acqui_cnt <= len_t'(1);
      end else if (acqui_cnt != '1) begin
        acqui_cnt <= acqui_cnt + 1'b1;
      end
    end
  end

  // snapshot of the event at its rising edge
  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      time_stamp         <= '0;
      baseline_when_hit  <= '0;
      threshold_when_hit <= '0;
    end else if (hit_rise) begin
      time_stamp         <= hit_time;
      baseline_when_hit  <= base;
      threshold_when_hit <= thresh;
    end
  end

endmodule

// File: trg_axil_regs.sv
module trg_axil_regs (
  input  logic                          AXIS_ACLK,
  input  logic                          hit_flag_negedge,
  input  logic [trg_pkg::axil_aw-1:0]   s_axil_awaddr,
  input  logic                          s_axil_awvalid,
  output logic                          s_axil_awready,
  input  logic [trg_pkg::axil_dw-1:0]   s_axil_wdata,
  input  logic [trg_pkg::axil_dw/8-1:0] s_axil_wstrb,
  input  logic                          s_axil_wvalid,
  output logic                          s_axil_wready,
  output logic [1:0]                    s_axil_bresp,
  output logic                          s_axil_bvalid,
  input  logic                          s_axil_bready,
  input  logic [trg_pkg::axil_aw-1:0]   s_axil_araddr,
  input  logic                          s_axil_arvalid,
  output logic                          s_axil_arready,
  output logic [trg_pkg::axil_dw-1:0]   s_axil_rdata,
  output logic [1:0]                    s_axil_rresp,
  output logic                          s_axil_rvalid,
  input  logic                          s_axil_rready,
  input  logic                          event_start,
  output trg_pkg::sample_t              thresh,
  output trg_pkg::sample_t              base,
  output trg_pkg::len_t                 post_len,
  output trg_pkg::len_t                 acqui_len,
  output logic                          enable,
  output trg_pkg::time_t                time_now
);
  import trg_pkg::*;

  localparam int strb_w = axil_dw / 8;

  logic               aw_take;
  logic               wr_en;
  logic               rd_en;
  logic [axil_aw-1:0] wr_addr;
  logic [axil_aw-1:0] rd_addr;
  logic               wr_err;
  logic [axil_dw-1:0] wr_old;
  logic [axil_dw-1:0] wr_val;
  logic [axil_dw-1:0] rd_mux;
  logic               rd_err;
  logic               clear_time;
  logic [axil_dw-1:0] evcnt;

  // byte-wise merge of write data into the current value
  function automatic logic [axil_dw-1:0] merge(
    input logic [axil_dw-1:0] old_val,
    input logic [axil_dw-1:0] new_val,
    input logic [strb_w-1:0]  strb
  );
    logic [axil_dw-1:0] res;
    res = old_val;
    for (int i = 0; i < strb_w; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  // unaligned offsets are unmapped
  assign wr_addr = s_axil_awaddr;
  assign rd_addr = s_axil_araddr;

  assign aw_take = !s_axil_awready && s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
  assign wr_en   = s_axil_awready && s_axil_awvalid && s_axil_wvalid;
  assign rd_en   = s_axil_arready && s_axil_arvalid;

  // current contents of the addressed writable register
  always_comb begin
    wr_old = '0;
    wr_err = 1'b0;
    case (wr_addr)
      reg_ctrl:   wr_old = {{(axil_dw-1){1'b0}}, enable};
      reg_thresh: wr_old = {{(axil_dw-adc_w){thresh[adc_w-1]}}, thresh};
      reg_base:   wr_old = {{(axil_dw-adc_w){base[adc_w-1]}}, base};
      reg_post:   wr_old = {{(axil_dw-len_w){1'b0}}, post_len};
      reg_acqui:  wr_old = {{(axil_dw-len_w){1'b0}}, acqui_len};
      default:    wr_err = 1'b1;
    endcase
  end

  assign wr_val = merge(wr_old, s_axil_wdata, s_axil_wstrb);

  // clear bit never stores, it only restarts the time base
  assign clear_time = wr_en && !wr_err && (wr_addr == reg_ctrl) && wr_val[ctrl_clear_bit];

  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      s_axil_awready <= 1'b0;
      s_axil_wready  <= 1'b0;
      s_axil_bvalid  <= 1'b0;
    end else begin
      s_axil_awready <= aw_take;
      s_axil_wready  <= aw_take;
      if (wr_en) begin
        s_axil_bvalid <= 1'b1;
      end else if (s_axil_bready) begin
        s_axil_bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge AXIS_ACLK) begin
    if (wr_en) begin
      s_axil_bresp <= wr_err ? resp_slverr : resp_okay;
    end
  end

  // configuration registers
  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      enable    <= enable_rst;
      thresh    <= thresh_rst;
      base      <= base_rst;
      post_len  <= post_rst;
      acqui_len <= acqui_rst;
    end else if (wr_en && !wr_err) begin
      case (wr_addr)
        reg_ctrl:   enable <= wr_val[ctrl_enable_bit];
        reg_thresh: thresh <= wr_val[adc_w-1:0];
        reg_base:   base <= wr_val[adc_w-1:0];
        reg_post:   post_len <= wr_val[len_w-1:0];
        reg_acqui:  acqui_len <= wr_val[len_w-1:0];
        default:    enable <= enable;
      endcase
    end
  end

  // free-running time base and event counter
  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      time_now <= '0;
      evcnt    <= '0;
    end else begin
      if (clear_time) begin
        time_now <= '0;
      end else begin
        time_now <= time_now + 1'b1;
      end
      if (event_start) begin
        evcnt <= evcnt + 1'b1;
      end
    end
  end

  always_comb begin
    rd_mux = '0;
    rd_err = 1'b0;
    case (rd_addr)
      reg_ctrl:    rd_mux = {{(axil_dw-1){1'b0}}, enable};
      reg_thresh:  rd_mux = {{(axil_dw-adc_w){thresh[adc_w-1]}}, thresh};
      reg_base:    rd_mux = {{(axil_dw-adc_w){base[adc_w-1]}}, base};
      reg_post:    rd_mux = {{(axil_dw-len_w){1'b0}}, post_len};
      reg_acqui:   rd_mux = {{(axil_dw-len_w){1'b0}}, acqui_len};
      reg_evcnt:   rd_mux = evcnt;
      reg_time_lo: rd_mux = time_now[axil_dw-1:0];
      reg_time_hi: rd_mux = {{(2*axil_dw-time_w){1'b0}}, time_now[time_w-1:axil_dw]};
      default:     rd_err = 1'b1;
    endcase
  end

  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      s_axil_arready <= 1'b0;
      s_axil_rvalid  <= 1'b0;
    end else begin
      s_axil_arready <= !s_axil_arready && s_axil_arvalid && !s_axil_rvalid;
      if (rd_en) begin
        s_axil_rvalid <= 1'b1;
      end else if (s_axil_rready) begin
        s_axil_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge AXIS_ACLK) begin
    if (rd_en) begin
      s_axil_rdata <= rd_mux;
      s_axil_rresp <= rd_err ? resp_slverr : resp_okay;
    end
  end

endmodule

// File: trg_top.sv
module trg_top (
  input  logic                          AXIS_ACLK,
  input  logic                          hit_flag_negedge,

  input  trg_pkg::beat_t                s_axis_tdata,
  input  logic                          s_axis_tvalid,

  input  logic [trg_pkg::axil_aw-1:0]   s_axil_awaddr,
  input  logic                          s_axil_awvalid,
  output logic                          s_axil_awready,
  input  logic [trg_pkg::axil_dw-1:0]   s_axil_wdata,
  input  logic [trg_pkg::axil_dw/8-1:0] s_axil_wstrb,
  input  logic                          s_axil_wvalid,
  output logic                          s_axil_wready,
  output logic [1:0]                    s_axil_bresp,
  output logic                          s_axil_bvalid,
  input  logic                          s_axil_bready,
  input  logic [trg_pkg::axil_aw-1:0]   s_axil_araddr,
  input  logic                          s_axil_arvalid,
  output logic                          s_axil_arready,
  output logic [trg_pkg::axil_dw-1:0]   s_axil_rdata,
  output logic [1:0]                    s_axil_rresp,
  output logic                          s_axil_rvalid,
  input  logic                          s_axil_rready,

  output trg_pkg::beat_t                m_axis_tdata,
  output logic                          m_axis_tvalid,

  output logic                          triggered,
  output trg_pkg::time_t                time_stamp,
  output trg_pkg::sample_t              baseline_when_hit,
  output trg_pkg::sample_t              threshold_when_hit
);
  import trg_pkg::*;

  sample_t thresh;
  sample_t base;
  len_t    post_len;
  len_t    acqui_len;
  logic    enable;
  time_t   time_now;
  logic    event_start;
  logic    hit;
  // time base and valid of the beat that hit refers to
  time_t   hit_time;
  logic    hit_valid;

  trg_axil_regs u_regs (
    .AXIS_ACLK        (AXIS_ACLK),
    .hit_flag_negedge (hit_flag_negedge),
    .s_axil_awaddr    (s_axil_awaddr),
    .s_axil_awvalid   (s_axil_awvalid),
    .s_axil_awready   (s_axil_awready),
    .s_axil_wdata     (s_axil_wdata),
    .s_axil_wstrb     (s_axil_wstrb),
    .s_axil_wvalid    (s_axil_wvalid),
    .s_axil_wready    (s_axil_wready),
    .s_axil_bresp     (s_axil_bresp),
    .s_axil_bvalid    (s_axil_bvalid),
    .s_axil_bready    (s_axil_bready),
    .s_axil_araddr    (s_axil_araddr),
    .s_axil_arvalid   (s_axil_arvalid),
    .s_axil_arready   (s_axil_arready),
    .s_axil_rdata     (s_axil_rdata),
    .s_axil_rresp     (s_axil_rresp),
    .s_axil_rvalid    (s_axil_rvalid),
    .s_axil_rready    (s_axil_rready),
    .event_start      (event_start),
    .thresh           (thresh),
    .base             (base),
    .post_len         (post_len),
    .acqui_len        (acqui_len),
    .enable           (enable),
    .time_now         (time_now)
  );

  trg_sample_compare u_cmp (
    .AXIS_ACLK        (AXIS_ACLK),
    .hit_flag_negedge (hit_flag_negedge),
    .s_axis_tdata     (s_axis_tdata),
    .s_axis_tvalid    (s_axis_tvalid),
    .enable           (enable),
    .thresh           (thresh),
    .base             (base),
    .hit              (hit)
  );

  // one stage, matches the compare register
  trg_align_pipe #(.payload_t(time_t), .depth(1)) u_time_pipe (
    .AXIS_ACLK        (AXIS_ACLK),
    .hit_flag_negedge (hit_flag_negedge),
    .in_data          (time_now),
    .in_valid         (s_axis_tvalid),
    .out_data         (hit_time),
    .out_valid        (hit_valid)
  );

  trg_window_ctrl u_win (
    .AXIS_ACLK          (AXIS_ACLK),
    .hit_flag_negedge   (hit_flag_negedge),
    .hit                (hit),
    .beat_valid         (hit_valid),
    .post_len           (post_len),
    .acqui_len          (acqui_len),
    .thresh             (thresh),
    .base               (base),
    .hit_time           (hit_time),
    .triggered          (triggered),
    .event_start        (event_start),
    .time_stamp         (time_stamp),
    .baseline_when_hit  (baseline_when_hit),
    .threshold_when_hit (threshold_when_hit)
  );

  // data lines up with the trigger mark
  trg_align_pipe #(.payload_t(beat_t), .depth(hit_lat)) u_data_pipe (
    .AXIS_ACLK        (AXIS_ACLK),
    .hit_flag_negedge (hit_flag_negedge),
    .in_data          (s_axis_tdata),
    .in_valid         (s_axis_tvalid),
    .out_data         (m_axis_tdata),
    .out_valid        (m_axis_tvalid)
  );

endmodule

// File: trg_tb.sv
module trg_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import trg_pkg::*;

  localparam int clk_half     = 50;
  localparam int reset_cycles = 8;
  // run length: reset, stream beats, register accesses, margin
  localparam int stream_beats = 200;
  localparam int bus_ops      = 48;
  localparam int op_cycles    = 6;
  localparam int cycle_limit  = reset_cycles + stream_beats + bus_ops * op_cycles + 100;

  typedef struct packed {
    logic    valid;
    beat_t   data;
    logic    mark;
    time_t   stamp;
    sample_t bh;
    sample_t th;
  } exp_t;

  logic                 AXIS_ACLK;
  logic                 hit_flag_negedge;
  beat_t                s_axis_tdata;
  logic                 s_axis_tvalid;
  logic [axil_aw-1:0]   s_axil_awaddr;
  logic                 s_axil_awvalid;
  logic                 s_axil_awready;
  logic [axil_dw-1:0]   s_axil_wdata;
  logic [axil_dw/8-1:0] s_axil_wstrb;
  logic                 s_axil_wvalid;
  logic                 s_axil_wready;
  logic [1:0]           s_axil_bresp;
  logic                 s_axil_bvalid;
  logic                 s_axil_bready;
  logic [axil_aw-1:0]   s_axil_araddr;
  logic                 s_axil_arvalid;
  logic                 s_axil_arready;
  logic [axil_dw-1:0]   s_axil_rdata;
  logic [1:0]           s_axil_rresp;
  logic                 s_axil_rvalid;
  logic                 s_axil_rready;
  beat_t                m_axis_tdata;
  logic                 m_axis_tvalid;
  logic                 triggered;
  time_t                time_stamp;
  sample_t              baseline_when_hit;
  sample_t              threshold_when_hit;

  // reference model state
  int      m_thresh;
  int      m_base;
  int      m_post;
  int      m_acqui;
  bit      m_enable;
  int      since_rise;
  int      since_fall;
  bit      h_prev;
  bit      post_ok;
  int      ev_cnt;
  time_t   e_stamp;
  sample_t e_bh;
  sample_t e_th;
  exp_t    exp_q[$];

  // time_now sampled at posedge e equals e - base_edge
  int          base_edge;
  int          cyc;
  int          wr_edge;
  int          rd_edge;
  int          test_errs;
  int          pass_cnt;
  int          fail_cnt;
  logic [31:0] rng;
  logic [31:0] rd_val;
  logic [1:0]  rd_resp;

  trg_top dut (.*);

  initial AXIS_ACLK = 1'b0;
  always #(clk_half) AXIS_ACLK = ~AXIS_ACLK;

  always @(posedge AXIS_ACLK) begin
    cyc <= cyc + 1;
    if (cyc >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng;
  endfunction

  function automatic beat_t put_lane(input beat_t b, input int idx, input int s);
    beat_t r;
    r = b;
    r[lane_w*idx + lane_w - adc_w +: adc_w] = s[adc_w-1:0];
    return r;
  endfunction

  // every lane just below base plus threshold
  function automatic beat_t quiet_beat();
    beat_t       b;
    logic [31:0] r;
    int          s;
    for (int i = 0; i < lanes; i++) begin
      r = lcg_next();
      s = m_base + m_thresh - 1 - int'(r[5:0]);
      b[lane_w*i +: lane_w] = {s[adc_w-1:0], r[9:6]};
    end
    return b;
  endfunction

  // one random lane exactly at base plus threshold
  function automatic beat_t hot_beat();
    logic [31:0] r;
    r = lcg_next();
    return put_lane(quiet_beat(), int'(r[2:0]), m_base + m_thresh);
  endfunction

  function automatic bit beat_hits(input beat_t d);
    logic signed [adc_w-1:0] s;
    for (int i = 0; i < lanes; i++) begin
      s = d[lane_w*i + lane_w - adc_w +: adc_w];
      if (int'(s) - m_base >= m_thresh) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic check_val(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      test_errs++;
    end
  endtask

  // one stream cycle: check the beat from two cycles back, then drive
  task automatic step(input logic v, input beat_t d);
    exp_t e;
    exp_t nx;
    bit   h;
    @(negedge AXIS_ACLK);
    if (exp_q.size() >= 2) begin
      e = exp_q.pop_front();
      check_val("m_axis_tvalid", m_axis_tvalid, e.valid);
      if (e.valid) begin
        check_val("m_axis_tdata", m_axis_tdata, e.data);
      end
      check_val("triggered", triggered, e.mark);
      check_val("time_stamp", time_stamp, e.stamp);
      check_val("baseline_when_hit", baseline_when_hit, e.bh);
      check_val("threshold_when_hit", threshold_when_hit, e.th);
    end
    h = v && m_enable && beat_hits(d);
    if (h && !h_prev) begin
      since_rise = 0;
      ev_cnt++;
      e_stamp = time_t'(cyc + 1 - base_edge);
      e_bh = sample_t'(m_base);
      e_th = sample_t'(m_thresh);
    end else begin
      since_rise++;
    end
    if (!h && h_prev) begin
      since_fall = 0;
      post_ok = 1'b1;
    end else begin
      since_fall++;
    end
    nx.valid = v;
    nx.data  = d;
    nx.mark  = v && (h || (post_ok && since_fall < m_post)) && (since_rise < m_acqui);
    nx.stamp = e_stamp;
    nx.bh    = e_bh;
    nx.th    = e_th;
    h_prev = h;
    exp_q.push_back(nx);
    s_axis_tvalid = v;
    s_axis_tdata  = d;
  endtask

  // long enough for any post window to run out
  task automatic idle(input int n);
    repeat (n) step(1'b0, quiet_beat());
  endtask

  task automatic write_reg(input logic [axil_aw-1:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic [1:0] exp_resp);
    @(negedge AXIS_ACLK);
    s_axil_awaddr  = addr;
    s_axil_wdata   = data;
    s_axil_wstrb   = strb;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid  = 1'b1;
    @(negedge AXIS_ACLK);
    while (!s_axil_awready) @(negedge AXIS_ACLK);
    check_val("s_axil_wready", s_axil_wready, 1'b1);
    @(negedge AXIS_ACLK);
    wr_edge = cyc;
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    while (!s_axil_bvalid) @(negedge AXIS_ACLK);
    check_val("s_axil_bresp", s_axil_bresp, exp_resp);
  endtask

  task automatic read_reg(input logic [axil_aw-1:0] addr);
    @(negedge AXIS_ACLK);
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    @(negedge AXIS_ACLK);
    while (!s_axil_arready) @(negedge AXIS_ACLK);
    @(negedge AXIS_ACLK);
    s_axil_arvalid = 1'b0;
    while (!s_axil_rvalid) @(negedge AXIS_ACLK);
    rd_edge = cyc;
    rd_val  = s_axil_rdata;
    rd_resp = s_axil_rresp;
  endtask

  task automatic read_expect(input logic [axil_aw-1:0] addr, input logic [31:0] exp,
                             input string name);
    read_reg(addr);
    check_val(name, rd_val, exp);
    check_val("s_axil_rresp", rd_resp, resp_okay);
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d errors", name, test_errs);
    if (test_errs == 0) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
    end
    test_errs = 0;
  endtask

  initial begin
    hit_flag_negedge = 1'b1;
    s_axis_tdata   = '0;
    s_axis_tvalid  = 1'b0;
    s_axil_awaddr  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b1;
    s_axil_araddr  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b1;
    rng = 32'd22933;
    cyc = 0;
    m_thresh = 100;
    m_base = 0;
    m_post = 38;
    m_acqui = 100;
    m_enable = 1'b1;
    since_rise = 1 << 20;
    since_fall = 0;
    h_prev = 1'b0;
    post_ok = 1'b0;
    ev_cnt = 0;
    e_stamp = '0;
    e_bh = '0;
    e_th = '0;
    base_edge = 0;
    test_errs = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    repeat (reset_cycles) @(negedge AXIS_ACLK);
    hit_flag_negedge = 1'b0;

    // reset values, merged byte writes, read-only targets
    read_reg(reg_time_lo);
    base_edge = rd_edge - int'(rd_val);
    read_expect(reg_ctrl, 32'h1, "reg_ctrl");
    read_expect(reg_thresh, 32'h64, "reg_thresh");
    read_expect(reg_base, 32'h0, "reg_base");
    read_expect(reg_post, 32'h26, "reg_post");
    read_expect(reg_acqui, 32'h64, "reg_acqui");
    read_expect(reg_evcnt, 32'h0, "reg_evcnt");
    read_expect(reg_time_hi, 32'h0, "reg_time_hi");
    // an offset between two registers is unmapped
    read_reg(5'h02);
    check_val("s_axil_rdata", rd_val, 32'h0);
    check_val("s_axil_rresp", rd_resp, resp_slverr);
    write_reg(reg_post, 32'hAAAA_1234, 4'b0010, resp_okay);
    read_expect(reg_post, 32'h1226, "reg_post");
    write_reg(reg_thresh, 32'h0000_0800, 4'b0010, resp_okay);
    read_expect(reg_thresh, 32'hFFFF_F864, "reg_thresh");
    write_reg(reg_acqui, 32'h0000_FF55, 4'b0001, resp_okay);
    read_expect(reg_acqui, 32'h55, "reg_acqui");
    write_reg(reg_evcnt, 32'h5, 4'hF, resp_slverr);
    write_reg(reg_time_lo, 32'h7, 4'hF, resp_slverr);
    read_expect(reg_evcnt, 32'h0, "reg_evcnt");
    write_reg(reg_thresh, 32'd100, 4'hF, resp_okay);
    write_reg(reg_base, 32'd200, 4'hF, resp_okay);
    write_reg(reg_post, 32'd6, 4'hF, resp_okay);
    write_reg(reg_acqui, 32'd20, 4'hF, resp_okay);
    m_thresh = 100;
    m_base = 200;
    m_post = 6;
    m_acqui = 20;
    end_test("registers");

    // random gaps in valid
    for (int i = 0; i < 48; i++) begin
      rd_val = lcg_next();
      step(rd_val[1:0] != 2'b00, quiet_beat());
    end
    idle(m_post + 4);
    end_test("pass_through");

    repeat (3) step(1'b1, quiet_beat());
    repeat (2) step(1'b1, put_lane(quiet_beat(), 5, m_base + m_thresh - 1));
    // would wrap without the extra bit
    step(1'b1, put_lane(quiet_beat(), 2, -2048));
    repeat (3) step(1'b1, hot_beat());
    repeat (2) step(1'b1, quiet_beat());
    step(1'b0, quiet_beat());
    repeat (m_post + 3) step(1'b1, quiet_beat());
    idle(m_post + 4);
    read_expect(reg_evcnt, ev_cnt, "reg_evcnt");
    end_test("trigger_post");

    repeat (m_acqui + 10) step(1'b1, hot_beat());
    repeat (2) step(1'b1, quiet_beat());
    repeat (2) step(1'b1, hot_beat());
    idle(m_post + 4);
    read_expect(reg_evcnt, ev_cnt, "reg_evcnt");
    end_test("over_length");

    read_reg(reg_time_lo);
    check_val("reg_time_lo", rd_val, rd_edge - base_edge);
    repeat (2) step(1'b1, hot_beat());
    idle(m_post + 4);
    write_reg(reg_thresh, 32'd90, 4'hF, resp_okay);
    write_reg(reg_base, 32'hFFFF_FFCE, 4'hF, resp_okay);
    m_thresh = 90;
    m_base = -50;
    repeat (4) step(1'b1, quiet_beat());
    step(1'b1, hot_beat());
    idle(m_post + 4);
    read_expect(reg_evcnt, ev_cnt, "reg_evcnt");
    end_test("capture");

    write_reg(reg_ctrl, 32'h0, 4'hF, resp_okay);
    m_enable = 1'b0;
    repeat (4) step(1'b1, hot_beat());
    idle(m_post + 4);
    read_expect(reg_evcnt, ev_cnt, "reg_evcnt");
    // enable back on together with a time-base clear
    write_reg(reg_ctrl, 32'h3, 4'hF, resp_okay);
    m_enable = 1'b1;
    base_edge = wr_edge + 1;
    read_reg(reg_time_lo);
    check_val("reg_time_lo", rd_val, rd_edge - base_edge);
    step(1'b1, hot_beat());
    idle(m_post + 4);
    read_expect(reg_evcnt, ev_cnt, "reg_evcnt");
    end_test("enable_clear");

    $display("summary: %0d tests clean, %0d tests with errors", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
trg_pkg.sv
trg_align_pipe.sv
trg_sample_compare.sv
trg_window_ctrl.sv
trg_axil_regs.sv
trg_top.sv
trg_tb.sv

// File: Bender.yml
package:
  name: trg

sources:
  - files:
      - trg_pkg.sv
      - trg_align_pipe.sv
      - trg_sample_compare.sv
      - trg_window_ctrl.sv
      - trg_axil_regs.sv
      - trg_top.sv
  - target: simulation
    files:
      - trg_tb.sv
